// File: logic/gbc_defines.svh
`ifndef GBC_DEFINES_SVH
`define GBC_DEFINES_SVH

////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////

// Opcode byte from the prefetch stage
`define GBC_OPCODE_W 8

// 8-bit register selector, B C D E H L - A
`define GBC_REG_SEL_W 3

////////////////////////////////////////////////////////////////////////
// Machine cycle limits
////////////////////////////////////////////////////////////////////////

`define GBC_MCYCLE_W 3

// Taken CALL is the longest instruction kept
`define GBC_MAX_MCYCLES 6

`endif

// File: logic/gbc_pkg.sv
`include "gbc_defines.svh"
`default_nettype none

package gbc_pkg;

    typedef enum logic [1:0] {
        BUS_IDLE  = 2'b00,
        BUS_FETCH = 2'b01,
        BUS_WRITE = 2'b10,
        BUS_READ  = 2'b11
    } bus_op_t;

    typedef enum logic [1:0] {
        AB_PC   = 2'b00,
        AB_SP   = 2'b01,
        AB_TEMP = 2'b10
    } ab_src_t;

    typedef enum logic [1:0] {
        CT_HOLD = 2'b00,
        CT_INC  = 2'b01,
        CT_DEC  = 2'b10
    } ct_op_t;

    typedef enum logic [1:0] {
        PC_SEQ  = 2'b00,
        PC_TEMP = 2'b10 // Jump target collected in the temp register
    } pc_src_t;

    typedef enum logic [1:0] {
        DST_NONE = 2'b00,
        DST_ACC  = 2'b01,
        DST_REG  = 2'b10,
        DST_PAIR = 2'b11
    } alu_dst_t;

    typedef enum logic [3:0] {
        CLS_NOP, CLS_ALU, CLS_LD_RR, CLS_LD_IMM16,
        CLS_JR, CLS_JP, CLS_CALL, CLS_PUSH,
        CLS_POP, CLS_HALT, CLS_STOP, CLS_UNSUPPORTED
    } instr_class_t;

    // Same order as opcode bits 4:3
    typedef enum logic [1:0] {
        COND_NZ = 2'b00,
        COND_Z  = 2'b01,
        COND_NC = 2'b10,
        COND_C  = 2'b11
    } cond_t;

    typedef struct packed {
        logic [2:0]                alu_op;
        logic [`GBC_REG_SEL_W-1:0] rf_rd_sel;
        logic [`GBC_REG_SEL_W-1:0] rf_wr_sel;
        alu_dst_t                  alu_dst;
        logic                      flags_we;
        bus_op_t                   bus_op;
        ab_src_t                   ab_src;
        ct_op_t                    ct_op;
        pc_src_t                   pc_src;
        logic                      pc_we;
        logic                      pc_jr;   // PC plus signed offset
        logic                      next;    // Another m-cycle follows
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: logic/opcode_decoder.sv
`include "gbc_defines.svh"
`default_nettype none

module opcode_decoder
    import gbc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      accept,
    input  logic [`GBC_OPCODE_W-1:0]  opcode_early,
    output instr_class_t              dec_class,
    output cond_t                     dec_cond,
    output logic                      dec_cond_always,
    output logic [`GBC_REG_SEL_W-1:0] dec_dst_sel,
    output logic [`GBC_REG_SEL_W-1:0] dec_src_sel,
    output logic [1:0]                dec_pair,
    output ctrl_word_t                dec_word
);

    ////////////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////////////

    function automatic instr_class_t classify(input logic [`GBC_OPCODE_W-1:0] op);
        instr_class_t cls;
        casez (op)
            8'h00: cls = CLS_NOP;
            8'h10: cls = CLS_STOP;
            8'h76: cls = CLS_HALT;
            8'b00??_0001: cls = CLS_LD_IMM16;
            8'h18, 8'h20, 8'h28, 8'h30, 8'h38: cls = CLS_JR;
            8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA: cls = CLS_JP;
            8'hCD, 8'hC4, 8'hCC, 8'hD4, 8'hDC: cls = CLS_CALL;
            8'b11??_0101: cls = CLS_PUSH;
            8'b11??_0001: cls = CLS_POP;
            8'b01??_????: begin
                // (HL) row and column not kept
                if (op[5:3] != 3'd6 && op[2:0] != 3'd6) begin
                    cls = CLS_LD_RR;
                end else begin
                    cls = CLS_UNSUPPORTED;
                end
            end
            8'b10??_????: begin
                if (op[2:0] != 3'd6) begin
                    cls = CLS_ALU;
                end else begin
                    cls = CLS_UNSUPPORTED;
                end
            end
            default: cls = CLS_UNSUPPORTED;
        endcase
        return cls;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Control word for m-cycle 0
    ////////////////////////////////////////////////////////////////////

    function automatic ctrl_word_t first_word(input instr_class_t cls,
                                              input logic [`GBC_OPCODE_W-1:0] op);
        ctrl_word_t w;
        w           = '0;
        w.bus_op    = BUS_FETCH; // Single-cycle default
        w.ab_src    = AB_PC;
        w.ct_op     = CT_INC;
        w.pc_src    = PC_SEQ;
        w.rf_rd_sel = op[2:0];
        w.rf_wr_sel = op[5:3];
        case (cls)
            CLS_ALU: begin
                w.alu_op    = op[5:3];
                w.rf_wr_sel = '1; // A
                w.alu_dst   = DST_ACC;
                w.flags_we  = 1'b1;
            end
            CLS_LD_RR: w.alu_dst = DST_REG;
            CLS_LD_IMM16, CLS_JR, CLS_JP, CLS_CALL: begin
                // First immediate byte
                w.bus_op = BUS_READ;
                w.next   = 1'b1;
            end
            CLS_POP: begin
                w.bus_op = BUS_READ;
                w.ab_src = AB_SP;
                w.next   = 1'b1;
            end
            CLS_PUSH: begin
                w.bus_op = BUS_IDLE; // SP predecrement only
                w.ab_src = AB_SP;
                w.ct_op  = CT_DEC;
                w.next   = 1'b1;
            end
            default: ;
        endcase
        return w;
    endfunction

    instr_class_t op_class;
    logic         op_always;

    assign op_class  = classify(opcode_early);
    assign op_always = (opcode_early == 8'h18) || (opcode_early == 8'hC3) ||
                       (opcode_early == 8'hCD);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_class       <= CLS_NOP;
            dec_cond_always <= 1'b0;
        end else if (accept) begin
            dec_class       <= op_class;
            dec_cond_always <= op_always;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_cond    <= cond_t'(opcode_early[4:3]);
            dec_dst_sel <= opcode_early[5:3];
            dec_src_sel <= opcode_early[2:0];
            dec_pair    <= opcode_early[5:4]; // BC DE HL AF/SP
            dec_word    <= first_word(op_class, opcode_early);
        end
    end

endmodule

`default_nettype wire

// File: logic/mcycle_sequencer.sv
`include "gbc_defines.svh"
`default_nettype none

module mcycle_sequencer
    import gbc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      op_valid,
    input  logic                      f_z,
    input  logic                      f_c,
    input  instr_class_t              dec_class,
    input  cond_t                     dec_cond,
    input  logic                      dec_cond_always,
    input  logic [`GBC_REG_SEL_W-1:0] dec_dst_sel,
    input  logic [`GBC_REG_SEL_W-1:0] dec_src_sel,
    input  logic [1:0]                dec_pair,
    input  ctrl_word_t                dec_word,
    output logic                      accept,
    output logic                      op_ready,
    output ctrl_word_t                ctrl,
    output logic                      ctrl_valid,
    output logic                      halt,
    output logic                      stop
);

    localparam logic [`GBC_MCYCLE_W-1:0] LAST_MCYCLE =
        `GBC_MCYCLE_W'(`GBC_MAX_MCYCLES - 1);
    localparam ctrl_word_t IDLE_WORD = '0;

    logic                      busy;
    logic [`GBC_MCYCLE_W-1:0]  m_cycle;
    logic                      cond_met;
    logic                      taken;
    logic [`GBC_REG_SEL_W-1:0] pair_hi;
    logic [`GBC_REG_SEL_W-1:0] pair_lo;
    ctrl_word_t                word;

    always_comb begin
        case (dec_cond)
            COND_NZ: cond_met = !f_z;
            COND_Z:  cond_met = f_z;
            COND_NC: cond_met = !f_c;
            default: cond_met = f_c;
        endcase
    end

    assign taken   = dec_cond_always || cond_met;
    assign pair_hi = {dec_pair, 1'b0};
    assign pair_lo = {dec_pair, 1'b1};

    ////////////////////////////////////////////////////////////////////
    // Per-cycle control word
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        word = dec_word;
        if (m_cycle != '0) begin
            // Later cycles start quiet and present the raw opcode fields
            word.rf_rd_sel = dec_src_sel;
            word.rf_wr_sel = dec_dst_sel;
            word.alu_dst   = DST_NONE;
            word.flags_we  = 1'b0;
            word.bus_op    = BUS_IDLE;
            word.ct_op     = CT_HOLD;
            word.pc_src    = PC_SEQ;
            word.pc_we     = 1'b0;
            word.pc_jr     = 1'b0;
            word.next      = 1'b0;
        end
        case (dec_class)
            CLS_LD_IMM16, CLS_POP: begin
                if (m_cycle == 3'd1) begin
                    word.bus_op = BUS_READ; // High byte, address source kept
                    word.ct_op  = CT_INC;
                    word.next   = 1'b1;
                end else if (m_cycle == 3'd2) begin
                    word.alu_dst   = DST_PAIR;
                    word.rf_wr_sel = pair_hi;
                end
            end
            CLS_PUSH: begin
                if (m_cycle == 3'd1) begin
                    word.bus_op    = BUS_WRITE;
                    word.ab_src    = AB_SP;
                    word.ct_op     = CT_DEC;
                    word.rf_rd_sel = pair_hi;
                    word.next      = 1'b1;
                end else if (m_cycle == 3'd2) begin
                    word.bus_op    = BUS_WRITE;
                    word.ab_src    = AB_SP;
                    word.rf_rd_sel = pair_lo;
                    word.next      = 1'b1;
                end
            end
            CLS_JR: begin
                if (m_cycle == 3'd1 && taken) begin
                    word.pc_jr = 1'b1;
                    word.next  = 1'b1;
                end
            end
            CLS_JP, CLS_CALL: begin
                if (m_cycle == 3'd1) begin
                    word.bus_op = BUS_READ;
                    word.ct_op  = CT_INC;
                    word.next   = 1'b1;
                end else if (m_cycle == 3'd2 && taken) begin
                    if (dec_class == CLS_JP) begin
                        word.pc_src = PC_TEMP;
                        word.pc_we  = 1'b1;
                    end else begin
                        word.ab_src = AB_SP; // Make room for return address
                        word.ct_op  = CT_DEC;
                    end
                    word.next = 1'b1;
                end else if (dec_class == CLS_CALL &&
                             (m_cycle == 3'd3 || m_cycle == 3'd4)) begin
                    word.bus_op = BUS_WRITE;
                    word.ab_src = AB_SP;
                    word.ct_op  = CT_DEC;
                    word.next   = 1'b1;
                    if (m_cycle == 3'd4) begin
                        word.pc_src = PC_TEMP;
                        word.pc_we  = 1'b1;
                    end
                end
            end
            default: ;
        endcase
        // Final cycle hands the bus back to opcode fetch
        if (!word.next || m_cycle == LAST_MCYCLE) begin
            word.next   = 1'b0;
            word.bus_op = BUS_FETCH;
            word.ab_src = AB_PC;
            word.ct_op  = CT_INC;
        end
    end

    assign ctrl       = busy ? word : IDLE_WORD;
    assign ctrl_valid = busy;
    assign op_ready   = !ctrl.next; // Idle or last cycle
    assign accept     = op_valid && op_ready;
    assign halt = busy && (dec_class == CLS_HALT || dec_class == CLS_UNSUPPORTED);
    assign stop = busy && (dec_class == CLS_STOP || dec_class == CLS_UNSUPPORTED);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            m_cycle <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            m_cycle <= '0;
        end else if (busy && word.next) begin
            m_cycle <= m_cycle + `GBC_MCYCLE_W'(1);
        end else begin
            busy    <= 1'b0;
            m_cycle <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/gb_control_unit.sv
`include "gbc_defines.svh"
`default_nettype none

module gb_control_unit
    import gbc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_valid,
    input  logic [`GBC_OPCODE_W-1:0] opcode_early,
    output logic                     op_ready,
    input  logic                     f_z,
    input  logic                     f_c,
    output ctrl_word_t               ctrl,
    output logic                     ctrl_valid,
    output logic                     halt,
    output logic                     stop
);

    logic                      accept;
    instr_class_t              dec_class;
    cond_t                     dec_cond;
    logic                      dec_cond_always;
    logic [`GBC_REG_SEL_W-1:0] dec_dst_sel;
    logic [`GBC_REG_SEL_W-1:0] dec_src_sel;
    logic [1:0]                dec_pair;
    ctrl_word_t                dec_word;

    // Registered decode, one cycle after accept
    opcode_decoder u_decoder (
        .clk             (clk),
        .rst             (rst),
        .accept          (accept),
        .opcode_early    (opcode_early),
        .dec_class       (dec_class),
        .dec_cond        (dec_cond),
        .dec_cond_always (dec_cond_always),
        .dec_dst_sel     (dec_dst_sel),
        .dec_src_sel     (dec_src_sel),
        .dec_pair        (dec_pair),
        .dec_word        (dec_word)
    );

    mcycle_sequencer u_sequencer (
        .clk             (clk),
        .rst             (rst),
        .op_valid        (op_valid),
        .f_z             (f_z),
        .f_c             (f_c),
        .dec_class       (dec_class),
        .dec_cond        (dec_cond),
        .dec_cond_always (dec_cond_always),
        .dec_dst_sel     (dec_dst_sel),
        .dec_src_sel     (dec_src_sel),
        .dec_pair        (dec_pair),
        .dec_word        (dec_word),
        .accept          (accept),
        .op_ready        (op_ready),
        .ctrl            (ctrl),
        .ctrl_valid      (ctrl_valid),
        .halt            (halt),
        .stop            (stop)
    );

endmodule

`default_nettype wire

// File: verification/gb_control_unit_assert.sv
`default_nettype none

module gb_control_unit_assert
    import gbc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       op_valid,
    input  logic       op_ready,
    input  ctrl_word_t ctrl,
    input  logic       ctrl_valid,
    input  logic       halt,
    input  logic       stop
);
    timeunit 1ns;
    timeprecision 1ps;

    // Registered decode puts m-cycle 0 one clock after acceptance
    a_accept_to_valid: assert property (@(posedge clk) disable iff (rst)
        (op_valid && op_ready) |=> ctrl_valid)
        else $error("ctrl_valid missing one cycle after an accepted opcode");

    a_pc_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.pc_we && ctrl.pc_jr))
        else $error("pc_we and pc_jr high in the same cycle");

    a_halt_stop_valid: assert property (@(posedge clk) disable iff (rst)
        (halt || stop) |-> ctrl_valid)
        else $error("halt or stop raised outside an instruction");

    a_ready_on_last: assert property (@(posedge clk) disable iff (rst)
        !ctrl.next |-> op_ready)
        else $error("op_ready low while no further m-cycle follows");

endmodule

bind gb_control_unit gb_control_unit_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .op_ready   (op_ready),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid),
    .halt       (halt),
    .stop       (stop)
);

`default_nettype wire

// File: verification/gb_control_unit_checker.sv
`include "gbc_defines.svh"
`default_nettype none

module gb_control_unit_checker
    import gbc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_valid,
    input  logic [`GBC_OPCODE_W-1:0] opcode_early,
    input  logic                     op_ready,
    input  logic                     f_z,
    input  logic                     f_c,
    input  ctrl_word_t               ctrl,
    input  logic                     ctrl_valid,
    input  logic                     halt,
    input  logic                     stop,
    output int                       checked,
    output int                       errors
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        instr_class_t cls;
        logic [3:0]   len;
        logic [2:0]   alu_op;
        logic [2:0]   rd_sel;
        logic [2:0]   wr_sel;
        alu_dst_t     dst;
        logic         flags_we;
        logic [1:0]   n_pc_we;
        logic [1:0]   n_pc_jr;
        logic [2:0]   pc_mcycle; // M-cycle of the PC update
        logic         halt;
        logic         stop;
    } expect_t;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic expect_t reference_result(input logic [`GBC_OPCODE_W-1:0] op,
                                                 input logic fz,
                                                 input logic fc);
        expect_t e;
        logic    cond_ok;
        logic    taken;
        e        = '0;
        e.cls    = CLS_UNSUPPORTED;
        e.len    = 4'd1;
        e.rd_sel = op[2:0];
        e.wr_sel = op[5:3];
        case (op[4:3]) // NZ Z NC C
            2'd0:    cond_ok = !fz;
            2'd1:    cond_ok = fz;
            2'd2:    cond_ok = !fc;
            default: cond_ok = fc;
        endcase
        taken = cond_ok || op == 8'h18 || op == 8'hC3 || op == 8'hCD;
        if (op == 8'h00) begin
            e.cls = CLS_NOP;
        end else if (op == 8'h10) begin
            e.cls = CLS_STOP;
        end else if (op == 8'h76) begin
            e.cls = CLS_HALT;
        end else if (op[7:6] == 2'b01) begin
            if (op[5:3] != 3'd6 && op[2:0] != 3'd6) e.cls = CLS_LD_RR;
        end else if (op[7:6] == 2'b10) begin
            if (op[2:0] != 3'd6) e.cls = CLS_ALU;
        end else if (op[7:6] == 2'b00 && op[3:0] == 4'h1) begin
            e.cls = CLS_LD_IMM16;
        end else if (op == 8'h18 || {op[7:5], op[2:0]} == 6'b001_000) begin
            e.cls = CLS_JR;
        end else if (op == 8'hC3 || {op[7:5], op[2:0]} == 6'b110_010) begin
            e.cls = CLS_JP;
        end else if (op == 8'hCD || {op[7:5], op[2:0]} == 6'b110_100) begin
            e.cls = CLS_CALL;
        end else if (op[7:6] == 2'b11 && op[3:0] == 4'h5) begin
            e.cls = CLS_PUSH;
        end else if (op[7:6] == 2'b11 && op[3:0] == 4'h1) begin
            e.cls = CLS_POP;
        end
        case (e.cls)
            CLS_ALU: begin
                e.alu_op   = op[5:3];
                e.wr_sel   = 3'd7; // Accumulator
                e.dst      = DST_ACC;
                e.flags_we = 1'b1;
            end
            CLS_LD_RR:             e.dst = DST_REG;
            CLS_LD_IMM16, CLS_POP: e.len = 4'd3;
            CLS_PUSH:              e.len = 4'd4;
            CLS_JR: begin
                e.len       = taken ? 4'd3 : 4'd2;
                e.n_pc_jr   = {1'b0, taken};
                e.pc_mcycle = 3'd1;
            end
            CLS_JP: begin
                e.len       = taken ? 4'd4 : 4'd3;
                e.n_pc_we   = {1'b0, taken};
                e.pc_mcycle = 3'd2;
            end
            CLS_CALL: begin
                e.len       = taken ? 4'd6 : 4'd3;
                e.n_pc_we   = {1'b0, taken};
                e.pc_mcycle = 3'd4;
            end
            CLS_HALT: e.halt = 1'b1;
            CLS_STOP: e.stop = 1'b1;
            CLS_UNSUPPORTED: begin
                e.halt = 1'b1;
                e.stop = 1'b1;
            end
            default: ;
        endcase
        return e;
    endfunction

    logic                     started;
    logic [`GBC_OPCODE_W-1:0] started_op;
    logic                     active;
    logic [`GBC_OPCODE_W-1:0] cur_op;
    expect_t                  exp_r;
    int                       cycle_cnt;
    int                       n_pc_we;
    int                       n_pc_jr;
    int                       instr_errors;
    int                       chk_total = 0;
    int                       err_total = 0;

    task automatic report_mismatch(input string what);
        $display("Fail at %0d ns: instruction #%0d opcode 0x%02h, %s",
                 $time, chk_total, cur_op, what);
        instr_errors++;
    endtask

    task automatic begin_instruction(input logic [`GBC_OPCODE_W-1:0] op);
        active       = 1'b1;
        cur_op       = op;
        exp_r        = reference_result(op, f_z, f_c); // Flags held for the instruction
        cycle_cnt    = 0;
        n_pc_we      = 0;
        n_pc_jr      = 0;
        instr_errors = 0;
    endtask

    task automatic close_instruction();
        if (instr_errors == 0) begin
            $display("ok   #%0d opcode 0x%02h %s, %0d cycles",
                     chk_total, cur_op, exp_r.cls.name(), cycle_cnt);
        end else begin
            err_total++;
        end
        chk_total++;
        active = 1'b0;
    endtask

    task automatic check_idle();
        if (ctrl_valid || ctrl.pc_we || ctrl.pc_jr || ctrl.flags_we || halt || stop ||
            !op_ready || ctrl.bus_op != BUS_IDLE) begin
            $display("Fail at %0d ns: outputs active while no instruction runs", $time);
            err_total++;
        end
    endtask

    task automatic check_cycle();
        if (!ctrl_valid) report_mismatch("ctrl_valid low inside the instruction");
        if (cycle_cnt == 0) begin
            if (ctrl.alu_dst != exp_r.dst) report_mismatch("alu_dst");
            if (ctrl.flags_we != exp_r.flags_we) report_mismatch("flags_we");
            if (exp_r.cls == CLS_ALU || exp_r.cls == CLS_LD_RR) begin
                if (ctrl.alu_op != exp_r.alu_op) report_mismatch("alu_op");
                if (ctrl.rf_rd_sel != exp_r.rd_sel) report_mismatch("rf_rd_sel");
                if (ctrl.rf_wr_sel != exp_r.wr_sel) report_mismatch("rf_wr_sel");
            end
        end else if (ctrl.flags_we) begin
            report_mismatch("flags_we after m-cycle 0");
        end
        if (ctrl.pc_we && ctrl.pc_jr) report_mismatch("pc_we and pc_jr together");
        if (ctrl.pc_we || ctrl.pc_jr) begin
            if (cycle_cnt != int'(exp_r.pc_mcycle)) report_mismatch("PC update m-cycle");
        end
        if (ctrl.pc_we && ctrl.pc_src != PC_TEMP) report_mismatch("pc_src");
        if (halt != exp_r.halt) report_mismatch("halt");
        if (stop != exp_r.stop) report_mismatch("stop");
        if (!ctrl.next && !op_ready) report_mismatch("op_ready low in the final cycle");
        if (ctrl.pc_we) n_pc_we++;
        if (ctrl.pc_jr) n_pc_jr++;
        cycle_cnt++;
        if (!ctrl.next || !ctrl_valid) begin
            if (cycle_cnt != int'(exp_r.len)) begin
                report_mismatch($sformatf("length %0d, expected %0d",
                                          cycle_cnt, exp_r.len));
            end
            if (ctrl.bus_op != BUS_FETCH || ctrl.ab_src != AB_PC || ctrl.ct_op != CT_INC) begin
                report_mismatch("final cycle is not an opcode fetch");
            end
            if (n_pc_we != int'(exp_r.n_pc_we)) report_mismatch("pc_we pulse count");
            if (n_pc_jr != int'(exp_r.n_pc_jr)) report_mismatch("pc_jr pulse count");
            close_instruction();
        end else if (cycle_cnt > `GBC_MAX_MCYCLES) begin
            $display("Error at %0d ns: instruction #%0d opcode 0x%02h never finished",
                     $time, chk_total, cur_op);
            instr_errors++;
            close_instruction();
        end
    endtask

    // Samples at the edge, so every value belongs to the cycle just ended
    always @(posedge clk) begin
        if (rst) begin
            started = 1'b0;
            active  = 1'b0;
        end else begin
            if (started) begin
                if (active) begin
                    report_mismatch("new opcode accepted before this one ended");
                    close_instruction();
                end
                begin_instruction(started_op);
            end
            if (active) begin
                check_cycle();
            end else begin
                check_idle();
            end
            started    = op_valid && op_ready;
            started_op = opcode_early;
        end
        checked <= chk_total;
        errors  <= err_total;
    end

endmodule

`default_nettype wire

// File: verification/gb_control_unit_tb.sv
`include "gbc_defines.svh"
`default_nettype none

module gb_control_unit_tb
    import gbc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCEPT_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT  = 200;
    localparam int RANDOM_COUNT   = 300;

    logic                     clk;
    logic                     rst;
    logic                     op_valid;
    logic [`GBC_OPCODE_W-1:0] opcode_early;
    logic                     f_z;
    logic                     f_c;
    logic                     op_ready;
    ctrl_word_t               ctrl;
    logic                     ctrl_valid;
    logic                     halt;
    logic                     stop;
    int                       checked;
    int                       errors;
    int                       sent;
    logic                     timed_out;

    always #2 clk = ~clk;

    gb_control_unit u_dut (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .opcode_early (opcode_early),
        .op_ready     (op_ready),
        .f_z          (f_z),
        .f_c          (f_c),
        .ctrl         (ctrl),
        .ctrl_valid   (ctrl_valid),
        .halt         (halt),
        .stop         (stop)
    );

    gb_control_unit_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .opcode_early (opcode_early),
        .op_ready     (op_ready),
        .f_z          (f_z),
        .f_c          (f_c),
        .ctrl         (ctrl),
        .ctrl_valid   (ctrl_valid),
        .halt         (halt),
        .stop         (stop),
        .checked      (checked),
        .errors       (errors)
    );

    // JR, JP, CALL in groups of five, unconditional form first
    function automatic logic [7:0] branch_opcode(input int idx);
        int         fam;
        int         k;
        logic [1:0] cc;
        fam = idx / 5;
        k   = idx % 5;
        cc  = 2'(k - 1);
        case (fam)
            0:       return (k == 0) ? 8'h18 : {3'b001, cc, 3'b000};
            1:       return (k == 0) ? 8'hC3 : {3'b110, cc, 3'b010};
            default: return (k == 0) ? 8'hCD : {3'b110, cc, 3'b100};
        endcase
    endfunction

    function automatic logic [7:0] random_opcode();
        int unsigned r;
        logic [1:0]  pair;
        logic [7:0]  op;
        r    = $urandom_range(9, 0);
        pair = 2'($urandom);
        case (r)
            0, 1, 2, 3: op = 8'($urandom_range(8'hBF, 8'h40)); // ALU and LD r,r
            4, 5, 6:    op = branch_opcode(int'($urandom_range(14, 0)));
            7:          op = {2'b00, pair, 4'h1};
            8:          op = $urandom_range(1, 0) == 0 ? {2'b11, pair, 4'h5}
                                                       : {2'b11, pair, 4'h1};
            default:    op = 8'($urandom);
        endcase
        return op;
    endfunction

    // Holds the opcode until accepted; flags change only at the accepting edge
    task automatic issue(input logic [7:0] op, input logic fz, input logic fc);
        int waited;
        waited       = 0;
        op_valid     <= 1'b1;
        opcode_early <= op;
        do begin
            @(posedge clk);
            waited++;
        end while (!op_ready && waited < ACCEPT_TIMEOUT);
        if (op_ready) begin
            f_z <= fz;
            f_c <= fc;
            sent++;
        end else begin
            $display("Timeout at %0d ns: opcode 0x%02h was never accepted", $time, op);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited   = 0;
        op_valid <= 1'b0;
        while (checked != sent && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (checked != sent) begin
            $display("Timeout at %0d ns: instruction never finished, %0d of %0d checked",
                     $time, checked, sent);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int i;
        int fl;
        clk          = 1'b0;
        rst          = 1'b1;
        op_valid     = 1'b0;
        opcode_early = '0;
        f_z          = 1'b0;
        f_c          = 1'b0;
        sent         = 0;
        timed_out    = 1'b0;
        void'($urandom(71660));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (6) @(posedge clk); // Idle outputs after reset

        for (i = 0; i < 256 && !timed_out; i++) begin
            issue(8'(i), 1'($urandom), 1'($urandom));
        end
        if (!timed_out) wait_drain();

        // Every branch form against every flag pair
        for (i = 0; i < 60 && !timed_out; i++) begin
            fl = i % 4;
            issue(branch_opcode(i / 4), fl[1], fl[0]);
        end
        if (!timed_out) wait_drain();

        for (i = 0; i < RANDOM_COUNT && !timed_out; i++) begin
            issue(random_opcode(), 1'($urandom), 1'($urandom));
        end
        if (!timed_out) wait_drain();

        $display("Summary: %0d sent, %0d checked, %0d passed, %0d errors",
                 sent, checked, checked - errors, errors);
        if (timed_out || errors != 0 || checked != sent) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: gb_control_unit.f
+incdir+logic
logic/gbc_pkg.sv
logic/opcode_decoder.sv
logic/mcycle_sequencer.sv
logic/gb_control_unit.sv
verification/gb_control_unit_assert.sv
verification/gb_control_unit_checker.sv
verification/gb_control_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
SIM_BIN=gb_control_unit_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module gb_control_unit_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f gb_control_unit.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG_FILE"; then
    echo "Simulation reported a failure"
    exit 1
fi
exit 0
